// File: bird_top.f
bird_pkg.sv
bird_regs.sv
random_lfsr.sv
bird_logic.sv
bird_sprite_draw.sv
bird_top.sv
tb_bird_top.sv

// File: tb_bird_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_bird_top;

	localparam int frame_len = 40; // cycles from one frame pulse to the next
	localparam int motion_frames = 2000; // per speed setting
	localparam int life_frames = 200; // bound on the hit and death phase
	localparam int cycle_limit = (4 * (motion_frames + 1) + life_frames + 4) * frame_len + 2000;

	logic clk, resetN;
	logic psel, penable, pwrite;
	logic [3:0] paddr;
	logic [31:0] pwdata, prdata;
	logic pready, pslverr;
	logic frame_start, hit;
	logic [10:0] pixel_x, pixel_y;
	logic draw_req;
	logic [7:0] bird_rgb;

	logic [31:0] lfsr_state = 32'h52b25cdd; // stimulus generator state
	int cycles = 0;
	int frame_mark = 0; // cycle of the last frame pulse
	int frame_no = 0;
	int fail_count = 0;
	logic [10:0] view_x, view_y; // bird state as read over apb
	logic view_alive, view_red, view_up;

	bird_top dut0 (
		.clk(clk), .resetN(resetN), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
		.frame_start(frame_start), .hit(hit), .pixel_x(pixel_x), .pixel_y(pixel_y),
		.draw_req(draw_req), .bird_rgb(bird_rgb)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = !clk; // 20 ns period
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles > cycle_limit) begin
			$display("timeout: tests did not finish within %0d cycles", cycle_limit);
			$display("STATUS: FAIL");
			$fatal(1);
		end
	end

	// fibonacci form, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic int rand_bits(input int n);
		int r;
		int k;
		r = 0;
		for (k = 0; k < n; k++) begin
			lfsr_state = lfsr_next(lfsr_state); // one step per bit
			r = (r << 1) | lfsr_state[0];
		end
		return r;
	endfunction

	// life after one frame, hits on a dead bird do nothing
	function automatic int exp_life(input int life, input logic h, input logic al);
		return (h && al && life > 0) ? life - 1 : life;
	endfunction

	// red frames left after one frame
	function automatic int exp_red(input int cnt, input logic h, input logic al);
		if (h && al)
			return bird_pkg::red_frames;
		return (cnt > 0) ? cnt - 1 : 0;
	endfunction

	function automatic logic inside_box(input logic [10:0] px, py, bx, by, input logic al);
		int ix, iy;
		ix = int'(px) - int'(bx);
		iy = int'(py) - int'(by);
		return al && (px < bird_pkg::screen_width) && (py < bird_pkg::screen_height) &&
			(ix >= 0) && (ix < bird_pkg::sprite_size) && (iy >= 0) && (iy < bird_pkg::sprite_size);
	endfunction

	function automatic int pixel_colour(input logic [10:0] py, by, input logic red, up);
		int iy;
		iy = int'(py) - int'(by); // row inside the box
		if (red)
			return bird_pkg::color_red;
		if (up ? (iy < bird_pkg::sprite_size / 4) : (iy >= bird_pkg::sprite_size * 3 / 4))
			return bird_pkg::color_wing;
		return bird_pkg::color_body;
	endfunction

	task automatic compare(input string name, input int exp, input int act);
		assert (exp == act) else begin
			fail_count++;
			$display("FAILED %s expected %0d actual %0d", name, exp, act);
			$display("STATUS: FAIL");
			$fatal(1);
		end
	endtask

	task automatic apb_xfer(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic err);
		@(negedge clk); // setup phase
		psel = 1'b1;
		penable = 1'b0;
		pwrite = wr;
		paddr = addr;
		pwdata = wdata;
		@(negedge clk); // access phase
		penable = 1'b1;
		#5 rdata = prdata;
		err = pslverr;
		compare("pready", 1, pready);
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic reg_read(input logic [3:0] addr, output logic [31:0] data);
		logic err;
		apb_xfer(1'b0, addr, 32'd0, data, err);
		compare("read_pslverr", 0, err);
	endtask

	task automatic reg_write(input logic [3:0] addr, input logic [31:0] data);
		logic [31:0] rd;
		logic err;
		apb_xfer(1'b1, addr, data, rd, err);
		compare("write_pslverr", 0, err);
	endtask

	task automatic next_frame(input logic h);
		while (cycles < frame_mark + frame_len - 1)
			@(negedge clk); // pad out the rest of the frame
		@(negedge clk);
		frame_start = 1'b1;
		hit = h; // sampled with the pulse only
		frame_mark = cycles;
		frame_no++;
		@(negedge clk);
		frame_start = 1'b0;
		hit = 1'b0;
	endtask

	task automatic probe_pixel(input logic [10:0] px, py);
		int e_in, e_rgb;
		e_in = inside_box(px, py, view_x, view_y, view_alive);
		e_rgb = e_in ? pixel_colour(py, view_y, view_red, view_up) : 0;
		@(negedge clk);
		pixel_x = px;
		pixel_y = py;
		@(negedge clk); // registered one cycle later
		compare("draw_req", e_in, draw_req);
		compare("bird_rgb", e_rgb, bird_rgb);
	endtask

	task automatic probe_box();
		probe_pixel(view_x, view_y); // four corners
		probe_pixel(view_x + 11'd31, view_y);
		probe_pixel(view_x, view_y + 11'd31);
		probe_pixel(view_x + 11'd31, view_y + 11'd31);
		probe_pixel(view_x - 11'd1, view_y); // just outside each edge
		probe_pixel(view_x + 11'd32, view_y);
		probe_pixel(view_x, view_y - 11'd1);
		probe_pixel(view_x, view_y + 11'd32);
		repeat (2)
			probe_pixel(view_x + 11'(rand_bits(6)) - 11'd16, view_y + 11'(rand_bits(6)) - 11'd16);
	endtask

	initial begin : main_seq
		logic [31:0] rd;
		logic err, h, m_alive, prev_up, saw_right, saw_left;
		int m_life, m_red, dead_frames, prev_x, dx, last_toggle, toggles, i, sp;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = 4'd0;
		pwdata = 32'd0;
		frame_start = 1'b0;
		hit = 1'b0;
		pixel_x = 11'd0;
		pixel_y = 11'd0;
		resetN = 1'b0;
		repeat (16) @(negedge clk);
		resetN = 1'b1;

		reg_read(bird_pkg::addr_status, rd); // only is_up after reset
		compare("status_reset", 32'h04, rd);
		reg_write(bird_pkg::addr_ctrl, 32'hFFFF_FFFF);
		reg_read(bird_pkg::addr_ctrl, rd);
		compare("ctrl_mask", 32'hF3, rd);
		apb_xfer(1'b0, 4'h1, 32'd0, rd, err);
		compare("unused_pslverr", 1, err);
		apb_xfer(1'b1, bird_pkg::addr_status, 32'd0, rd, err);
		compare("status_write_pslverr", 1, err);

		reg_write(bird_pkg::addr_ctrl, 32'h51); // life 5, speed 1
		reg_write(bird_pkg::addr_cmd, 32'h1);
		next_frame(1'b0);
		reg_read(bird_pkg::addr_pos, rd);
		compare("deploy_pos", {5'd0, 11'd185, 5'd0, 11'd280}, rd);
		reg_read(bird_pkg::addr_status, rd);
		compare("deploy_life", 5, rd[7:4]);
		compare("deploy_alive", 1, rd[0]);
		m_life = 5;
		m_red = 0;
		dead_frames = 0;
		for (i = 0; i < life_frames && dead_frames < 40; i++) begin
			m_alive = (m_life != 0) || (m_red != 0);
			h = ((m_life != 0) || !m_alive) && (rand_bits(2) == 3); // let the last flash end
			next_frame(h);
			m_life = exp_life(m_life, h, m_alive);
			m_red = exp_red(m_red, h, m_alive);
			reg_read(bird_pkg::addr_status, rd);
			compare("life", m_life, rd[7:4]);
			compare("red", m_red != 0, rd[1]);
			compare("alive", (m_life != 0) || (m_red != 0), rd[0]);
			dead_frames += !rd[0];
			view_alive = (m_life != 0) || (m_red != 0);
			view_red = (m_red != 0);
			view_up = ((frame_no / bird_pkg::wing_period) % 2) == 0; // flips every wing period
			compare("is_up", view_up, rd[2]);
			reg_read(bird_pkg::addr_pos, rd);
			view_x = rd[10:0];
			view_y = rd[26:16];
			probe_box();
		end
		compare("bird_died", 1, dead_frames >= 40);

		saw_right = 1'b0;
		saw_left = 1'b0;
		toggles = 0;
		for (sp = 0; sp < 4; sp++) begin
			reg_write(bird_pkg::addr_ctrl, 32'hF0 | sp);
			reg_write(bird_pkg::addr_cmd, 32'h1); // redeploy at the start point
			next_frame(1'b0);
			reg_read(bird_pkg::addr_pos, rd);
			compare("deploy_x", bird_pkg::initial_x, rd[10:0]);
			prev_x = rd[10:0];
			reg_read(bird_pkg::addr_status, rd);
			prev_up = rd[2];
			last_toggle = -1; // first toggle only sets the phase
			for (i = 0; i < motion_frames; i++) begin
				next_frame(1'b0);
				reg_read(bird_pkg::addr_pos, rd);
				compare("pos_y", bird_pkg::initial_y, rd[26:16]);
				compare("x_in_range", 1, rd[10:0] <= bird_pkg::max_x);
				dx = int'(rd[10:0]) - prev_x;
				compare("x_step", 1, (dx >= -2) && (dx <= 2));
				saw_right |= (dx > 0);
				saw_left |= (dx < 0);
				prev_x = rd[10:0];
				reg_read(bird_pkg::addr_status, rd);
				if (rd[2] != prev_up) begin
					if (last_toggle >= 0)
						compare("wing_period", bird_pkg::wing_period, frame_no - last_toggle);
					last_toggle = frame_no;
					toggles++;
				end
				prev_up = rd[2];
			end
		end
		compare("x_moved_right", 1, saw_right);
		compare("x_moved_left", 1, saw_left);
		compare("wing_toggles", 1, toggles > 8);

		if (fail_count == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: bird_top.sv
`timescale 1ns/1ns
`default_nettype none

module bird_top #(
	parameter int random_offset = 0
) (
	input logic clk,
	input logic resetN,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [3:0] paddr,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	input logic frame_start,
	input logic hit,
	input logic [bird_pkg::coord_w-1:0] pixel_x,
	input logic [bird_pkg::coord_w-1:0] pixel_y,
	output logic draw_req,
	output logic [7:0] bird_rgb
);

	logic [1:0] speed;
	logic [3:0] starting_life;
	logic deploy_req, deploy_ack;
	logic alive, red, is_up;
	logic [3:0] life;
	logic [bird_pkg::coord_w-1:0] x, y;
	logic [7:0] random;

	bird_regs regs0 (
		.clk(clk), .resetN(resetN),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.speed(speed), .starting_life(starting_life), .deploy_req(deploy_req),
		.deploy_ack(deploy_ack), .alive(alive), .red(red), .is_up(is_up),
		.life(life), .x(x), .y(y)
	);

	random_lfsr lfsr0 (
		.clk(clk), .resetN(resetN), .frame_start(frame_start), .random(random)
	);

	bird_logic #(.random_offset(random_offset)) logic0 (
		.clk(clk), .resetN(resetN), .frame_start(frame_start), .hit(hit),
		.random(random), .speed(speed), .starting_life(starting_life),
		.deploy_req(deploy_req), .deploy_ack(deploy_ack),
		.alive(alive), .red(red), .is_up(is_up), .life(life), .x(x), .y(y)
	);

	bird_sprite_draw draw0 (
		.clk(clk), .resetN(resetN), .pixel_x(pixel_x), .pixel_y(pixel_y),
		.alive(alive), .red(red), .is_up(is_up), .x(x), .y(y),
		.draw_req(draw_req), .bird_rgb(bird_rgb)
	);

endmodule

`default_nettype wire

// File: bird_sprite_draw.sv
`timescale 1ns/1ns
`default_nettype none

module bird_sprite_draw (
	input logic clk,
	input logic resetN,
	input logic [bird_pkg::coord_w-1:0] pixel_x, // current scan position
	input logic [bird_pkg::coord_w-1:0] pixel_y,
	input logic alive,
	input logic red,
	input logic is_up,
	input logic [bird_pkg::coord_w-1:0] x, // bird top-left corner
	input logic [bird_pkg::coord_w-1:0] y,
	output logic draw_req,
	output logic [7:0] bird_rgb
);

	localparam int band = bird_pkg::sprite_size / 4; // wing band height

	logic [bird_pkg::coord_w-1:0] rel_x, rel_y; // offset inside the box
	logic visible;
	logic in_box;
	logic wing_row;
	logic [7:0] colour;

	assign rel_x = pixel_x - x;
	assign rel_y = pixel_y - y;

	assign visible = (pixel_x < bird_pkg::screen_width) && (pixel_y < bird_pkg::screen_height);

	assign in_box = alive && visible &&
		(pixel_x >= x) && (rel_x < bird_pkg::sprite_size) &&
		(pixel_y >= y) && (rel_y < bird_pkg::sprite_size);

	// wings up paint the top quarter, wings down the bottom quarter
	assign wing_row = is_up ? (rel_y < band) : (rel_y >= bird_pkg::sprite_size - band);

	always_comb begin
		if (red)
			colour = bird_pkg::color_red; // hit flash overrides all
		else if (wing_row)
			colour = bird_pkg::color_wing;
		else
			colour = bird_pkg::color_body;
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			draw_req <= 1'b0;
			bird_rgb <= 8'd0;
		end else begin
			draw_req <= in_box; // one cycle behind the pixel
			bird_rgb <= in_box ? colour : 8'd0;
		end
	end

endmodule

`default_nettype wire

// File: bird_logic.sv
`timescale 1ns/1ns
`default_nettype none

module bird_logic #(
	parameter int random_offset = 0 // lets several birds share one random source
) (
	input logic clk,
	input logic resetN,
	input logic frame_start, // one pulse per frame
	input logic hit, // valid with frame_start only
	input logic [7:0] random,
	input logic [1:0] speed,
	input logic [3:0] starting_life,
	input logic deploy_req,
	output logic deploy_ack,
	output logic alive,
	output logic red,
	output logic is_up,
	output logic [3:0] life,
	output logic [bird_pkg::coord_w-1:0] x,
	output logic [bird_pkg::coord_w-1:0] y
);

	localparam logic [1:0] st_idle = 2'd0;
	localparam logic [1:0] st_right = 2'd1;
	localparam logic [1:0] st_left = 2'd2;

	localparam logic [16:0] init_x_fp = 17'(bird_pkg::initial_x << bird_pkg::fixed_shift);
	localparam logic [16:0] max_x_fp = 17'(bird_pkg::max_x << bird_pkg::fixed_shift);
	localparam logic [5:0] wing_last = 6'(bird_pkg::wing_period - 1);

	logic [1:0] state, next_state;
	logic [16:0] x_fp; // left edge in 1/64 pixel
	logic [16:0] step;
	logic [16:0] x_right, x_left; // clamped candidates
	logic [8:0] rand_sum, rand_val;
	logic [5:0] red_cnt; // frames left red
	logic [5:0] wing_cnt;

	assign step = 17'(bird_pkg::base_step + bird_pkg::speed_step * speed);

	// offset the shared random byte and fold back into 0..255
	assign rand_sum = {1'b0, random} + 9'(random_offset);
	assign rand_val = (rand_sum > 9'd255) ? rand_sum - 9'd255 : rand_sum;

	always_comb begin
		next_state = state;
		if (rand_val < 9'(bird_pkg::chance_to_change)) begin
			if (state == st_idle)
				next_state = (rand_val < 9'(bird_pkg::chance_to_change / 2)) ? st_right : st_left;
			else
				next_state = st_idle; // any move ends back in idle
		end
	end

	// position integral, clamped to 0..max_x
	assign x_right = (x_fp + step > max_x_fp) ? max_x_fp : x_fp + step;
	assign x_left = (x_fp < step) ? 17'd0 : x_fp - step;

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			state <= st_idle;
			x_fp <= init_x_fp;
			life <= 4'd0; // no bird until deploy
			red_cnt <= 6'd0;
			wing_cnt <= 6'd0;
			is_up <= 1'b1;
		end else if (frame_start) begin
			state <= next_state;
			red_cnt <= (red_cnt != 6'd0) ? red_cnt - 6'd1 : 6'd0;
			if (wing_cnt == wing_last) begin
				wing_cnt <= 6'd0;
				is_up <= !is_up; // flap
			end else begin
				wing_cnt <= wing_cnt + 6'd1;
			end
			if (deploy_req) begin
				state <= st_idle;
				life <= starting_life;
				x_fp <= init_x_fp; // back to the start point
			end else begin
				if (hit && alive) begin
					life <= (life != 4'd0) ? life - 4'd1 : 4'd0;
					red_cnt <= 6'(bird_pkg::red_frames); // restart flash
				end
				case (state)
					st_right: x_fp <= x_right;
					st_left: x_fp <= x_left;
					default: x_fp <= x_fp;
				endcase
			end
		end
	end

	assign deploy_ack = frame_start && deploy_req; // regs drop the request on this
	assign red = (red_cnt != 6'd0);
	assign alive = (life != 4'd0) || red; // stays visible until the flash ends

	assign x = 11'(x_fp >> bird_pkg::fixed_shift);
	assign y = 11'(bird_pkg::initial_y); // horizontal flight only

	// clamp keeps the sprite on screen
	a_x_range: assert property (@(posedge clk) disable iff (!resetN)
		x <= 11'(bird_pkg::max_x));

	// life only grows through a deploy from the register block
	a_life_no_rise: assert property (@(posedge clk) disable iff (!resetN)
		!(frame_start && deploy_req) |=> life <= $past(life));

endmodule

`default_nettype wire

// File: random_lfsr.sv
`timescale 1ns/1ns
`default_nettype none

module random_lfsr (
	input logic clk,
	input logic resetN,
	input logic frame_start,
	output logic [7:0] random
);

	logic [7:0] lfsr;

	// galois form of x^8 + x^6 + x^5 + x^4 + 1, period 255
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN)
			lfsr <= 8'h5A; // any nonzero seed
		else if (frame_start)
			lfsr <= lfsr[0] ? ((lfsr >> 1) ^ 8'hB8) : (lfsr >> 1);
	end

	assign random = lfsr;

	// zero is a lock-up state of the generator
	a_nonzero: assert property (@(posedge clk) disable iff (!resetN)
		lfsr != 8'd0);

endmodule

`default_nettype wire

// File: bird_regs.sv
`timescale 1ns/1ns
`default_nettype none

module bird_regs (
	input logic clk,
	input logic resetN,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [3:0] paddr,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic [1:0] speed,
	output logic [3:0] starting_life,
	output logic deploy_req,
	input logic deploy_ack, // frame logic took the request
	input logic alive,
	input logic red,
	input logic is_up,
	input logic [3:0] life,
	input logic [bird_pkg::coord_w-1:0] x,
	input logic [bird_pkg::coord_w-1:0] y
);

	logic access; // apb access phase
	logic wr_en;
	logic addr_ok; // offset hits one of the four registers
	logic ro_write; // write to status or pos
	logic [31:0] rd_mux;

	assign access = psel && penable;
	assign wr_en = access && pwrite;

	assign addr_ok = (paddr == bird_pkg::addr_ctrl) || (paddr == bird_pkg::addr_cmd) ||
		(paddr == bird_pkg::addr_status) || (paddr == bird_pkg::addr_pos);
	assign ro_write = pwrite &&
		((paddr == bird_pkg::addr_status) || (paddr == bird_pkg::addr_pos));

	assign pready = 1'b1; // no wait states
	assign pslverr = access && (!addr_ok || ro_write);

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			speed <= 2'd0;
			starting_life <= 4'd3; // ctrl resets to 0x30
			deploy_req <= 1'b0;
		end else begin
			if (wr_en && (paddr == bird_pkg::addr_ctrl)) begin
				speed <= pwdata[1:0];
				starting_life <= pwdata[7:4];
			end
			if (wr_en && (paddr == bird_pkg::addr_cmd) && pwdata[0])
				deploy_req <= 1'b1; // sticky, merges repeated writes
			else if (deploy_ack)
				deploy_req <= 1'b0; // consumed at frame start
		end
	end

	always_comb begin
		case (paddr)
			bird_pkg::addr_ctrl: rd_mux = {24'd0, starting_life, 2'd0, speed};
			bird_pkg::addr_status: rd_mux = {24'd0, life, 1'b0, is_up, red, alive};
			bird_pkg::addr_pos: rd_mux = {5'd0, y, 5'd0, x};
			default: rd_mux = 32'd0; // cmd is write-only
		endcase
	end

	assign prdata = (access && !pwrite) ? rd_mux : 32'd0;

	// apb protocol from the bus master side
	a_penable_psel: assert property (@(posedge clk) disable iff (!resetN)
		penable |-> psel);

	// frame logic must only acknowledge a pending deploy
	a_ack_req: assert property (@(posedge clk) disable iff (!resetN)
		deploy_ack |-> deploy_req);

endmodule

`default_nettype wire

// File: bird_pkg.sv
`default_nettype none

package bird_pkg;

	// visible area of the 640x480 screen
	localparam int screen_width = 640;
	localparam int screen_height = 480;

	localparam int sprite_size = 32; // bird box, square
	localparam int coord_w = 11; // bits per pixel coordinate

	// positions kept in 1/64 pixel units
	localparam int fixed_shift = 6;

	localparam int initial_x = 280; // left edge at reset and deploy
	localparam int initial_y = 185; // top edge, never changes
	localparam int max_x = screen_width - sprite_size; // 608, rightmost left edge

	// fixed-point step per frame = base_step + speed_step * speed
	localparam int base_step = 50;
	localparam int speed_step = 20;

	localparam int chance_to_change = 8; // random below this flips the move state
	localparam int red_frames = 32; // flash length after a hit
	localparam int wing_period = 33; // frames between wing toggles

	// apb byte offsets
	localparam logic [3:0] addr_ctrl = 4'h0;
	localparam logic [3:0] addr_cmd = 4'h4;
	localparam logic [3:0] addr_status = 4'h8;
	localparam logic [3:0] addr_pos = 4'hC;

	// rgb332 colours of the sprite
	localparam logic [7:0] color_red = 8'hE0;
	localparam logic [7:0] color_wing = 8'hFC;
	localparam logic [7:0] color_body = 8'h8C;

endpackage

`default_nettype wire
